//--- common/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// l1 geometry.
`define L1_NUM_SETS   16
`define L1_NUM_WAYS   2
`define L1_LINE_BITS  128
`define L1_WORD_BITS  32
`define L1_LINE_WORDS (`L1_LINE_BITS / `L1_WORD_BITS)

// physical address fields.
`define PADDR_BITS    32
`define L1_OFS_BITS   4
`define L1_WSEL_LO    2    // word select within a line.
`define L1_WSEL_HI    3
`define L1_SET_LO     4
`define L1_SET_HI     7
`define L1_TAG_LO     8
`define L1_TAG_HI     31

`endif

//--- common/mem_types_pkg.sv
`include "mem_consts.svh"

package mem_types_pkg;

    typedef logic [`PADDR_BITS-1:0]             t_paddr;
    typedef logic [`L1_SET_HI-`L1_SET_LO:0]     t_l1_set;
    typedef logic [$clog2(`L1_NUM_WAYS)-1:0]    t_l1_way;
    typedef logic [`L1_TAG_HI-`L1_TAG_LO:0]     t_l1_tag;
    typedef logic [`L1_WORD_BITS-1:0]           t_word;

    // word 0 sits in the low bits.
    typedef t_word [`L1_LINE_WORDS-1:0]         t_cl;

    typedef enum logic [1:0] {
        MESI_I = 2'd0,
        MESI_S = 2'd1,
        MESI_E = 2'd2,
        MESI_M = 2'd3
    } t_mesi;

endpackage

//--- common/mempipe_pkg.sv
package mempipe_pkg;

    // request kinds that enter mm1.
    typedef enum logic [1:0] {
        ARB_LOAD      = 2'd0,
        ARB_STORE     = 2'd1,
        ARB_FILL      = 2'd2,
        ARB_SNOOP_INV = 2'd3
    } t_arb_type;

endpackage

//--- mempipe/l1_tag_state.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module l1_tag_state (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rd_en,
    input  mem_types_pkg::t_l1_set  rd_set,
    output mem_types_pkg::t_l1_tag  rd_tags [`L1_NUM_WAYS],
    output mem_types_pkg::t_mesi    rd_states [`L1_NUM_WAYS],
    input  logic                    tag_wr_en,
    input  logic                    state_wr_en,
    input  mem_types_pkg::t_l1_set  wr_set,
    input  mem_types_pkg::t_l1_way  wr_way,
    input  mem_types_pkg::t_l1_tag  wr_tag,
    input  mem_types_pkg::t_mesi    wr_state,
    input  mem_types_pkg::t_l1_set  peek_set,
    input  mem_types_pkg::t_l1_way  peek_way,
    output mem_types_pkg::t_l1_tag  peek_tag,
    output mem_types_pkg::t_mesi    peek_state
);

    mem_types_pkg::t_l1_tag tag_array [`L1_NUM_SETS][`L1_NUM_WAYS];
    mem_types_pkg::t_mesi   state_array [`L1_NUM_SETS][`L1_NUM_WAYS];

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_tags   <= tag_array[rd_set];
            rd_states <= state_array[rd_set];
        end
        if (tag_wr_en)
            tag_array[wr_set][wr_way] <= wr_tag;
    end

    // every line starts invalid.
    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int s = 0; s < `L1_NUM_SETS; s++) begin
                for (int w = 0; w < `L1_NUM_WAYS; w++)
                    state_array[s][w] <= mem_types_pkg::MESI_I;
            end
        end else if (state_wr_en) begin
            state_array[wr_set][wr_way] <= wr_state;
        end
    end

    assign peek_tag   = tag_array[peek_set][peek_way];
    assign peek_state = state_array[peek_set][peek_way];

endmodule

//--- mempipe/l1_data.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module l1_data (
    input  logic                    clk,
    input  logic                    rd_en,
    input  mem_types_pkg::t_l1_set  rd_set,
    output mem_types_pkg::t_cl      rd_lines [`L1_NUM_WAYS],
    input  logic                    wr_en,
    input  mem_types_pkg::t_l1_set  wr_set,
    input  mem_types_pkg::t_l1_way  wr_way,
    input  mem_types_pkg::t_cl      wr_line,
    input  mem_types_pkg::t_l1_set  peek_set,
    input  mem_types_pkg::t_l1_way  peek_way,
    output mem_types_pkg::t_cl      peek_line
);

    mem_types_pkg::t_cl data_array [`L1_NUM_SETS][`L1_NUM_WAYS];

    always_ff @(posedge clk) begin
        if (rd_en)
            rd_lines <= data_array[rd_set];     // both ways of the set.
        if (wr_en)
            data_array[wr_set][wr_way] <= wr_line;
    end

    assign peek_line = data_array[peek_set][peek_way];

endmodule

//--- mempipe/l1_change_log.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module l1_change_log (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    tag_wr_en,
    input  logic                    state_wr_en,
    input  logic                    data_wr_en,
    input  mem_types_pkg::t_paddr   mm4_paddr,
    input  mempipe_pkg::t_arb_type  mm4_arb,
    input  mem_types_pkg::t_l1_way  mm4_way,
    output mem_types_pkg::t_l1_set  peek_set,
    output mem_types_pkg::t_l1_way  peek_way,
    input  mem_types_pkg::t_l1_tag  peek_tag,
    input  mem_types_pkg::t_mesi    peek_state,
    input  mem_types_pkg::t_cl      peek_line,
    output logic                    diff_valid,
    output mempipe_pkg::t_arb_type  diff_arb,
    output mem_types_pkg::t_l1_set  diff_set,
    output mem_types_pkg::t_l1_way  diff_way,
    output mem_types_pkg::t_mesi    diff_state,
    output mem_types_pkg::t_paddr   diff_paddr,
    output mem_types_pkg::t_cl      diff_line
);

    logic tag_wr_en_mm3;
    logic tag_wr_en_mm4;
    logic state_wr_en_mm3;
    logic state_wr_en_mm4;
    logic data_wr_en_mm4;

    // walk the write enables down to mm4.
    always_ff @(posedge clk) begin
        if (!reset) begin
            tag_wr_en_mm3   <= 1'b0;
            tag_wr_en_mm4   <= 1'b0;
            state_wr_en_mm3 <= 1'b0;
            state_wr_en_mm4 <= 1'b0;
            data_wr_en_mm4  <= 1'b0;
        end else begin
            tag_wr_en_mm3   <= tag_wr_en;
            tag_wr_en_mm4   <= tag_wr_en_mm3;
            state_wr_en_mm3 <= state_wr_en;
            state_wr_en_mm4 <= state_wr_en_mm3;
            data_wr_en_mm4  <= data_wr_en;
        end
    end

    assign peek_set = mm4_paddr[`L1_SET_HI:`L1_SET_LO];
    assign peek_way = mm4_way;

    // all writes of the request have landed by mm4.
    assign diff_valid = tag_wr_en_mm4 || state_wr_en_mm4 || data_wr_en_mm4;
    assign diff_arb   = mm4_arb;
    assign diff_set   = peek_set;
    assign diff_way   = peek_way;
    assign diff_state = peek_state;
    assign diff_line  = peek_line;

    always_comb begin
        diff_paddr[`L1_TAG_HI:`L1_TAG_LO] = peek_tag;
        diff_paddr[`L1_SET_HI:`L1_SET_LO] = peek_set;
        diff_paddr[`L1_OFS_BITS-1:0]      = '0;   // line aligned.
    end

endmodule

//--- mempipe/l1_mempipe.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module l1_mempipe (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    input  mempipe_pkg::t_arb_type  req_arb,
    input  mem_types_pkg::t_paddr   req_paddr,
    input  mem_types_pkg::t_cl      req_data,
    input  mem_types_pkg::t_mesi    req_state,
    output logic                    tag_rd_en,
    output mem_types_pkg::t_l1_set  rd_set,
    input  mem_types_pkg::t_l1_tag  rd_tags [`L1_NUM_WAYS],
    input  mem_types_pkg::t_mesi    rd_states [`L1_NUM_WAYS],
    output logic                    tag_wr_en,
    output logic                    state_wr_en,
    output mem_types_pkg::t_l1_set  wr_set_mm2,
    output mem_types_pkg::t_l1_way  wr_way_mm2,
    output mem_types_pkg::t_l1_tag  wr_tag_mm2,
    output mem_types_pkg::t_mesi    wr_state_mm2,
    output logic                    data_rd_en,
    input  mem_types_pkg::t_cl      rd_lines [`L1_NUM_WAYS],
    output logic                    data_wr_en,
    output mem_types_pkg::t_l1_set  data_wr_set_mm3,
    output mem_types_pkg::t_l1_way  data_wr_way_mm3,
    output mem_types_pkg::t_cl      data_wr_line_mm3,
    output mem_types_pkg::t_paddr   mm4_paddr,
    output mempipe_pkg::t_arb_type  mm4_arb,
    output mem_types_pkg::t_l1_way  mm4_way,
    output logic                    resp_valid,
    output mempipe_pkg::t_arb_type  resp_arb,
    output logic                    resp_hit,
    output mem_types_pkg::t_word    resp_word,
    output logic                    resp_dirty,
    output mem_types_pkg::t_cl      resp_line
);

    logic                               mm2_valid;
    mempipe_pkg::t_arb_type             mm2_arb;
    mem_types_pkg::t_paddr              mm2_paddr;
    mem_types_pkg::t_cl                 mm2_data;
    mem_types_pkg::t_mesi               mm2_fill_state;
    mem_types_pkg::t_l1_set             mm2_set;
    mem_types_pkg::t_l1_tag             mm2_tag;
    logic [`L1_NUM_WAYS-1:0]            mm2_way_hit;
    logic                               mm2_hit;
    mem_types_pkg::t_l1_way             mm2_hit_way;
    mem_types_pkg::t_l1_way             mm2_way;
    mem_types_pkg::t_mesi               mm2_old_state;
    logic                               mm2_is_fill;
    logic                               mm2_is_store;
    logic                               mm2_is_snoop;
    logic                               mm2_store_ok;
    logic [`L1_NUM_SETS-1:0]            victim;

    logic                               mm3_valid;
    mempipe_pkg::t_arb_type             mm3_arb;
    mem_types_pkg::t_paddr              mm3_paddr;
    mem_types_pkg::t_l1_way             mm3_way;
    logic                               mm3_hit;
    logic                               mm3_dirty;
    logic                               mm3_data_wr;
    mem_types_pkg::t_cl                 mm3_line;
    mem_types_pkg::t_cl                 mm3_data;
    mem_types_pkg::t_cl                 mm3_merged;
    logic [`L1_WSEL_HI-`L1_WSEL_LO:0]   mm3_wsel;

    // mm1 reads go straight from the request.
    assign tag_rd_en  = req_valid;
    assign data_rd_en = req_valid;
    assign rd_set     = req_paddr[`L1_SET_HI:`L1_SET_LO];

    always_ff @(posedge clk) begin
        if (!reset) begin
            mm2_valid <= 1'b0;
            mm3_valid <= 1'b0;
        end else begin
            mm2_valid <= req_valid;
            mm3_valid <= mm2_valid;
        end
    end

    always_ff @(posedge clk) begin
        mm2_arb        <= req_arb;
        mm2_paddr      <= req_paddr;
        mm2_data       <= req_data;
        mm2_fill_state <= req_state;
    end

    assign mm2_set      = mm2_paddr[`L1_SET_HI:`L1_SET_LO];
    assign mm2_tag      = mm2_paddr[`L1_TAG_HI:`L1_TAG_LO];
    assign mm2_is_fill  = (mm2_arb == mempipe_pkg::ARB_FILL);
    assign mm2_is_store = (mm2_arb == mempipe_pkg::ARB_STORE);
    assign mm2_is_snoop = (mm2_arb == mempipe_pkg::ARB_SNOOP_INV);

    always_comb begin
        mm2_hit_way = '0;
        for (int w = 0; w < `L1_NUM_WAYS; w++) begin
            mm2_way_hit[w] = (rd_states[w] != mem_types_pkg::MESI_I) && (rd_tags[w] == mm2_tag);
            if (mm2_way_hit[w])
                mm2_hit_way = mem_types_pkg::t_l1_way'(w);
        end
    end

    assign mm2_hit       = |mm2_way_hit;
    assign mm2_way       = (mm2_is_fill && !mm2_hit) ? victim[mm2_set] : mm2_hit_way;
    assign mm2_old_state = rd_states[mm2_way];
    assign mm2_store_ok  = mm2_is_store && mm2_hit &&
                           (mm2_old_state == mem_types_pkg::MESI_E ||
                            mm2_old_state == mem_types_pkg::MESI_M);

    // tag and state writes land at the end of mm2.
    assign tag_wr_en   = mm2_valid && mm2_is_fill;
    assign state_wr_en = mm2_valid && (mm2_is_fill ||
                         (mm2_store_ok && mm2_old_state == mem_types_pkg::MESI_E) ||
                         (mm2_is_snoop && mm2_hit));
    assign wr_set_mm2  = mm2_set;
    assign wr_way_mm2  = mm2_way;
    assign wr_tag_mm2  = mm2_tag;

    always_comb begin
        if (mm2_is_fill)
            wr_state_mm2 = mm2_fill_state;
        else if (mm2_is_store)
            wr_state_mm2 = mem_types_pkg::MESI_M;
        else
            wr_state_mm2 = mem_types_pkg::MESI_I;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            victim <= '0;
        end else if (mm2_valid && mm2_is_fill) begin
            victim[mm2_set] <= ~victim[mm2_set]; // round robin per set.
        end
    end

    always_ff @(posedge clk) begin
        mm3_arb     <= mm2_arb;
        mm3_paddr   <= mm2_paddr;
        mm3_way     <= mm2_way;
        mm3_hit     <= mm2_is_store ? mm2_store_ok : mm2_hit;
        mm3_dirty   <= mm2_is_snoop && mm2_hit && (mm2_old_state == mem_types_pkg::MESI_M);
        mm3_data_wr <= mm2_is_fill || mm2_store_ok;
        mm3_line    <= rd_lines[mm2_way];
        mm3_data    <= mm2_data;
    end

    assign mm3_wsel = mm3_paddr[`L1_WSEL_HI:`L1_WSEL_LO];

    always_comb begin
        mm3_merged           = mm3_line;
        mm3_merged[mm3_wsel] = mm3_data[0]; // store word rides in word 0.
    end

    assign data_wr_en       = mm3_valid && mm3_data_wr;
    assign data_wr_set_mm3  = mm3_paddr[`L1_SET_HI:`L1_SET_LO];
    assign data_wr_way_mm3  = mm3_way;
    assign data_wr_line_mm3 = (mm3_arb == mempipe_pkg::ARB_FILL) ? mm3_data : mm3_merged;

    assign resp_valid = mm3_valid;
    assign resp_arb   = mm3_arb;
    assign resp_hit   = mm3_hit;
    assign resp_word  = mm3_line[mm3_wsel];
    assign resp_dirty = mm3_dirty;
    assign resp_line  = mm3_line;

    always_ff @(posedge clk) begin
        mm4_paddr <= mm3_paddr;
        mm4_arb   <= mm3_arb;
        mm4_way   <= mm3_way;
    end

endmodule

//--- verilog/l1_cache_top.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module l1_cache_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    input  mempipe_pkg::t_arb_type  req_arb,
    input  mem_types_pkg::t_paddr   req_paddr,
    input  mem_types_pkg::t_cl      req_data,
    input  mem_types_pkg::t_mesi    req_state,
    output logic                    resp_valid,
    output mempipe_pkg::t_arb_type  resp_arb,
    output logic                    resp_hit,
    output mem_types_pkg::t_word    resp_word,
    output logic                    resp_dirty,
    output mem_types_pkg::t_cl      resp_line,
    output logic                    diff_valid,
    output mempipe_pkg::t_arb_type  diff_arb,
    output mem_types_pkg::t_l1_set  diff_set,
    output mem_types_pkg::t_l1_way  diff_way,
    output mem_types_pkg::t_mesi    diff_state,
    output mem_types_pkg::t_paddr   diff_paddr,
    output mem_types_pkg::t_cl      diff_line
);

    logic                   tag_rd_en;
    logic                   data_rd_en;
    mem_types_pkg::t_l1_set rd_set;
    mem_types_pkg::t_l1_tag rd_tags [`L1_NUM_WAYS];
    mem_types_pkg::t_mesi   rd_states [`L1_NUM_WAYS];
    mem_types_pkg::t_cl     rd_lines [`L1_NUM_WAYS];
    logic                   tag_wr_en;
    logic                   state_wr_en;
    mem_types_pkg::t_l1_set wr_set_mm2;
    mem_types_pkg::t_l1_way wr_way_mm2;
    mem_types_pkg::t_l1_tag wr_tag_mm2;
    mem_types_pkg::t_mesi   wr_state_mm2;
    logic                   data_wr_en;
    mem_types_pkg::t_l1_set data_wr_set_mm3;
    mem_types_pkg::t_l1_way data_wr_way_mm3;
    mem_types_pkg::t_cl     data_wr_line_mm3;
    mem_types_pkg::t_paddr  mm4_paddr;
    mempipe_pkg::t_arb_type mm4_arb;
    mem_types_pkg::t_l1_way mm4_way;
    mem_types_pkg::t_l1_set peek_set;
    mem_types_pkg::t_l1_way peek_way;
    mem_types_pkg::t_l1_tag peek_tag;
    mem_types_pkg::t_mesi   peek_state;
    mem_types_pkg::t_cl     peek_line;

    l1_mempipe mempipe (
        .clk, .reset, .req_valid, .req_arb, .req_paddr, .req_data, .req_state,
        .tag_rd_en, .rd_set, .rd_tags, .rd_states,
        .tag_wr_en, .state_wr_en, .wr_set_mm2, .wr_way_mm2, .wr_tag_mm2, .wr_state_mm2,
        .data_rd_en, .rd_lines,
        .data_wr_en, .data_wr_set_mm3, .data_wr_way_mm3, .data_wr_line_mm3,
        .mm4_paddr, .mm4_arb, .mm4_way,
        .resp_valid, .resp_arb, .resp_hit, .resp_word, .resp_dirty, .resp_line
    );

    l1_tag_state l1tag (
        .clk, .reset,
        .rd_en      (tag_rd_en),
        .rd_set, .rd_tags, .rd_states,
        .tag_wr_en, .state_wr_en,
        .wr_set     (wr_set_mm2),
        .wr_way     (wr_way_mm2),
        .wr_tag     (wr_tag_mm2),
        .wr_state   (wr_state_mm2),
        .peek_set, .peek_way, .peek_tag, .peek_state
    );

    l1_data l1data (
        .clk,
        .rd_en      (data_rd_en),
        .rd_set, .rd_lines,
        .wr_en      (data_wr_en),
        .wr_set     (data_wr_set_mm3),
        .wr_way     (data_wr_way_mm3),
        .wr_line    (data_wr_line_mm3),
        .peek_set, .peek_way, .peek_line
    );

    l1_change_log change_log (
        .clk, .reset, .tag_wr_en, .state_wr_en, .data_wr_en,
        .mm4_paddr, .mm4_arb, .mm4_way,
        .peek_set, .peek_way, .peek_tag, .peek_state, .peek_line,
        .diff_valid, .diff_arb, .diff_set, .diff_way, .diff_state, .diff_paddr, .diff_line
    );

endmodule

//--- verification/l1_cache_tb.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module l1_cache_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_DIRECTED    = 38;
    localparam int NUM_RANDOM      = 200;
    localparam int WATCHDOG_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 4 + 8 + 50;

    typedef struct packed {
        logic [63:0]            due;
        mempipe_pkg::t_arb_type arb;
        logic                   hit;
        mem_types_pkg::t_word   word;
        logic                   dirty;
        mem_types_pkg::t_cl     line;
        logic                   known;     // old line was written by an earlier fill.
    } resp_entry;

    typedef struct packed {
        logic [63:0]            due;
        mempipe_pkg::t_arb_type arb;
        mem_types_pkg::t_l1_set set;
        mem_types_pkg::t_l1_way way;
        mem_types_pkg::t_mesi   state;
        mem_types_pkg::t_paddr  paddr;
        mem_types_pkg::t_cl     line;
    } diff_entry;

    logic                   clk;
    logic                   reset;
    logic                   req_valid;
    mempipe_pkg::t_arb_type req_arb;
    mem_types_pkg::t_paddr  req_paddr;
    mem_types_pkg::t_cl     req_data;
    mem_types_pkg::t_mesi   req_state;
    logic                   resp_valid;
    mempipe_pkg::t_arb_type resp_arb;
    logic                   resp_hit;
    mem_types_pkg::t_word   resp_word;
    logic                   resp_dirty;
    mem_types_pkg::t_cl     resp_line;
    logic                   diff_valid;
    mempipe_pkg::t_arb_type diff_arb;
    mem_types_pkg::t_l1_set diff_set;
    mem_types_pkg::t_l1_way diff_way;
    mem_types_pkg::t_mesi   diff_state;
    mem_types_pkg::t_paddr  diff_paddr;
    mem_types_pkg::t_cl     diff_line;

    // reference cache contents.
    mem_types_pkg::t_l1_tag m_tag [`L1_NUM_SETS][`L1_NUM_WAYS];
    mem_types_pkg::t_mesi   m_state [`L1_NUM_SETS][`L1_NUM_WAYS];
    mem_types_pkg::t_cl     m_line [`L1_NUM_SETS][`L1_NUM_WAYS];
    logic                   m_known [`L1_NUM_SETS][`L1_NUM_WAYS];
    logic                   m_victim [`L1_NUM_SETS];

    resp_entry              resp_q [$];
    diff_entry              diff_q [$];
    resp_entry              exp_resp;
    diff_entry              exp_diff;
    logic                   check_en;
    integer                 seed;

    l1_cache_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all requests completed");
        $display("Verification failed");
        $fatal(1, "simulation timeout");
    end

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected) else begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "output mismatch");
        end
    endtask

    function automatic mem_types_pkg::t_paddr make_paddr(input mem_types_pkg::t_l1_tag tag,
                                                         input mem_types_pkg::t_l1_set set,
                                                         input logic [1:0] wsel);
        return {tag, set, wsel, 2'b00};
    endfunction

    function automatic mem_types_pkg::t_cl random_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // applies one request to the model and queues what the DUT must show.
    task automatic model_request(input mempipe_pkg::t_arb_type arb,
                                 input mem_types_pkg::t_paddr paddr,
                                 input mem_types_pkg::t_cl data,
                                 input mem_types_pkg::t_mesi fstate);
        mem_types_pkg::t_l1_set set;
        mem_types_pkg::t_l1_tag tag;
        logic [1:0]             wsel;
        logic                   hit;
        logic                   store_ok;
        logic                   changed;
        mem_types_pkg::t_l1_way way;
        mem_types_pkg::t_mesi   old_state;
        resp_entry              re;
        diff_entry              de;
        set = paddr[`L1_SET_HI:`L1_SET_LO];
        tag = paddr[`L1_TAG_HI:`L1_TAG_LO];
        wsel = paddr[3:2];
        hit = 1'b0;
        way = '0;
        for (int w = 0; w < `L1_NUM_WAYS; w++) begin
            if (m_state[set][w] != mem_types_pkg::MESI_I && m_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (arb == mempipe_pkg::ARB_FILL && !hit)
            way = m_victim[set];
        old_state = m_state[set][way];
        store_ok = (arb == mempipe_pkg::ARB_STORE) && hit &&
                   (old_state == mem_types_pkg::MESI_E || old_state == mem_types_pkg::MESI_M);
        re.due = $time + 2 * CLK_PERIOD;
        re.arb = arb;
        re.hit = (arb == mempipe_pkg::ARB_STORE) ? store_ok : hit;
        re.word = m_line[set][way][wsel];
        re.dirty = (arb == mempipe_pkg::ARB_SNOOP_INV) && hit &&
                   (old_state == mem_types_pkg::MESI_M);
        re.line = m_line[set][way];
        re.known = m_known[set][way];
        resp_q.push_back(re);
        changed = 1'b0;
        if (arb == mempipe_pkg::ARB_FILL) begin
            m_tag[set][way] = tag;
            m_state[set][way] = fstate;
            m_line[set][way] = data;
            m_known[set][way] = 1'b1;
            m_victim[set] = ~m_victim[set];
            changed = 1'b1;
        end else if (store_ok) begin
            m_line[set][way][wsel] = data[0];
            m_state[set][way] = mem_types_pkg::MESI_M;
            changed = 1'b1;
        end else if (arb == mempipe_pkg::ARB_SNOOP_INV && hit) begin
            m_state[set][way] = mem_types_pkg::MESI_I;
            changed = 1'b1;
        end
        if (changed) begin
            de.due = $time + 3 * CLK_PERIOD;
            de.arb = arb;
            de.set = set;
            de.way = way;
            de.state = m_state[set][way];
            de.paddr = {tag, set, {`L1_OFS_BITS{1'b0}}};
            de.line = m_line[set][way];
            diff_q.push_back(de);
        end
    endtask

    task automatic issue_request(input mempipe_pkg::t_arb_type arb,
                                 input mem_types_pkg::t_paddr paddr,
                                 input mem_types_pkg::t_cl data,
                                 input mem_types_pkg::t_mesi fstate);
        @(negedge clk);
        req_valid = 1'b1;
        req_arb   = arb;
        req_paddr = paddr;
        req_data  = data;
        req_state = fstate;
        model_request(arb, paddr, data, fstate);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    // keeps same-set requests three cycles apart.
    task automatic spaced_request(input mempipe_pkg::t_arb_type arb,
                                  input mem_types_pkg::t_paddr paddr,
                                  input mem_types_pkg::t_cl data,
                                  input mem_types_pkg::t_mesi fstate);
        issue_request(arb, paddr, data, fstate);
        idle_cycles(2);
    endtask

    always @(negedge clk) begin
        if (check_en) begin
            if (resp_q.size() > 0 && resp_q[0].due == $time) begin
                exp_resp = resp_q.pop_front();
                check_value("resp_valid", 1'b1, resp_valid);
                check_value("resp_arb", exp_resp.arb, resp_arb);
                check_value("resp_hit", exp_resp.hit, resp_hit);
                check_value("resp_dirty", exp_resp.dirty, resp_dirty);
                if (exp_resp.known) begin
                    check_value("resp_word", exp_resp.word, resp_word);
                    check_value("resp_line", exp_resp.line, resp_line);
                end
            end else begin
                check_value("resp_valid", 1'b0, resp_valid);
            end
            if (diff_q.size() > 0 && diff_q[0].due == $time) begin
                exp_diff = diff_q.pop_front();
                check_value("diff_valid", 1'b1, diff_valid);
                check_value("diff_arb", exp_diff.arb, diff_arb);
                check_value("diff_set", exp_diff.set, diff_set);
                check_value("diff_way", exp_diff.way, diff_way);
                check_value("diff_state", exp_diff.state, diff_state);
                check_value("diff_paddr", exp_diff.paddr, diff_paddr);
                check_value("diff_line", exp_diff.line, diff_line);
            end else begin
                check_value("diff_valid", 1'b0, diff_valid);
            end
        end
    end

    // stage valids are cleared after two edges of reset.
    initial begin
        check_en = 1'b0;
        repeat (2) @(posedge clk);
        check_en = 1'b1;
    end

    initial begin
        mem_types_pkg::t_l1_set set;
        mem_types_pkg::t_l1_set last1;
        mem_types_pkg::t_l1_set last2;
        mem_types_pkg::t_l1_tag tag;
        mempipe_pkg::t_arb_type arb;
        logic [31:0]            rnd;
        seed      = 32'h28fc;
        reset     = 1'b0;
        req_valid = 1'b0;
        req_arb   = mempipe_pkg::ARB_LOAD;
        req_paddr = '0;
        req_data  = '0;
        req_state = mem_types_pkg::MESI_I;
        for (int s = 0; s < `L1_NUM_SETS; s++) begin
            m_victim[s] = 1'b0;
            for (int w = 0; w < `L1_NUM_WAYS; w++) begin
                m_state[s][w] = mem_types_pkg::MESI_I;
                m_tag[s][w]   = '0;
                m_line[s][w]  = '0;
                m_known[s][w] = 1'b0;
            end
        end
        repeat (8) @(negedge clk);
        reset = 1'b1;
        idle_cycles(2);

        // empty cache, every set misses.
        for (int s = 0; s < `L1_NUM_SETS; s++)
            issue_request(mempipe_pkg::ARB_LOAD, make_paddr(24'h000100, s, 2'd0), '0,
                          mem_types_pkg::MESI_I);
        idle_cycles(3);

        // fill then read back each word.
        spaced_request(mempipe_pkg::ARB_FILL, make_paddr(24'h0abcde, 4'd3, 2'd0),
                       {32'h4444_0003, 32'h3333_0002, 32'h2222_0001, 32'h1111_0000},
                       mem_types_pkg::MESI_E);
        for (int w = 0; w < 4; w++)
            spaced_request(mempipe_pkg::ARB_LOAD, make_paddr(24'h0abcde, 4'd3, w), '0,
                           mem_types_pkg::MESI_I);

        // stores to E, to M, then to S.
        spaced_request(mempipe_pkg::ARB_STORE, make_paddr(24'h0abcde, 4'd3, 2'd2),
                       {96'h0, 32'hdead_beef}, mem_types_pkg::MESI_I);
        spaced_request(mempipe_pkg::ARB_STORE, make_paddr(24'h0abcde, 4'd3, 2'd1),
                       {96'h0, 32'hcafe_f00d}, mem_types_pkg::MESI_I);
        spaced_request(mempipe_pkg::ARB_FILL, make_paddr(24'h000555, 4'd5, 2'd0),
                       random_line(), mem_types_pkg::MESI_S);
        spaced_request(mempipe_pkg::ARB_STORE, make_paddr(24'h000555, 4'd5, 2'd3),
                       {96'h0, 32'h0bad_0bad}, mem_types_pkg::MESI_I);
        spaced_request(mempipe_pkg::ARB_LOAD, make_paddr(24'h0abcde, 4'd3, 2'd2), '0,
                       mem_types_pkg::MESI_I);

        // snoops on M and E lines, then on a miss.
        spaced_request(mempipe_pkg::ARB_SNOOP_INV, make_paddr(24'h0abcde, 4'd3, 2'd0), '0,
                       mem_types_pkg::MESI_I);
        spaced_request(mempipe_pkg::ARB_LOAD, make_paddr(24'h0abcde, 4'd3, 2'd0), '0,
                       mem_types_pkg::MESI_I);
        spaced_request(mempipe_pkg::ARB_FILL, make_paddr(24'h070707, 4'd7, 2'd0),
                       random_line(), mem_types_pkg::MESI_E);
        spaced_request(mempipe_pkg::ARB_SNOOP_INV, make_paddr(24'h070707, 4'd7, 2'd1), '0,
                       mem_types_pkg::MESI_I);
        spaced_request(mempipe_pkg::ARB_LOAD, make_paddr(24'h070707, 4'd7, 2'd0), '0,
                       mem_types_pkg::MESI_I);
        spaced_request(mempipe_pkg::ARB_SNOOP_INV, make_paddr(24'h070707, 4'd7, 2'd0), '0,
                       mem_types_pkg::MESI_I);

        // three fills into one set walk the victim bit.
        for (int i = 0; i < 3; i++)
            spaced_request(mempipe_pkg::ARB_FILL, make_paddr(24'h000a00 + i, 4'd9, 2'd0),
                           random_line(), mem_types_pkg::MESI_S);
        for (int i = 0; i < 3; i++)
            spaced_request(mempipe_pkg::ARB_LOAD, make_paddr(24'h000a00 + i, 4'd9, 2'd1), '0,
                           mem_types_pkg::MESI_I);

        // back to back random stream, no set repeats within three requests.
        last1 = 4'd0;
        last2 = 4'd0;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            do begin
                rnd = $random(seed);
                set = rnd[3:0];
            end while (set == last1 || set == last2);
            rnd = $random(seed);
            arb = mempipe_pkg::t_arb_type'(rnd[1:0]);
            tag = 24'h00b000 + rnd[3:2];
            rnd = $random(seed);
            issue_request(arb, make_paddr(tag, set, rnd[1:0]), random_line(),
                          mem_types_pkg::t_mesi'(rnd[5:4]));
            last2 = last1;
            last1 = set;
        end
        idle_cycles(6);

        if (resp_q.size() == 0 && diff_q.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("expected responses or diffs never appeared at the outputs");
            $display("Verification failed");
            $fatal(1, "pending expectations at end of run");
        end
    end

endmodule

//--- build.f
+incdir+common
common/mem_types_pkg.sv
common/mempipe_pkg.sv
mempipe/l1_tag_state.sv
mempipe/l1_data.sv
mempipe/l1_change_log.sv
mempipe/l1_mempipe.sv
verilog/l1_cache_top.sv
verification/l1_cache_tb.sv
